//--- rtl/ctrlPkg.sv
package ctrlPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    typedef logic [2:0] aluOp_t;
    typedef logic [2:0] pcSource_t;
    typedef logic [1:0] regDst_t;
    typedef logic [2:0] memToReg_t;
    typedef logic [1:0] aluSrcA_t;
    typedef logic [1:0] aluSrcB_t;
    typedef logic [2:0] iorD_t;

    typedef enum logic [4:0] {
        FETCH1, FETCH2, FETCH3,
        DECODE1, DECODE2,
        EXECUTE,
        WRITE_RD, IMM_CHECK, WRITE_RT,
        MEM_WAIT1, MEM_WAIT2, MEM_ACCESS,
        BRANCH, JUMP,
        MULDIV_WAIT, HILO_WB,
        EXC_SAVE, EXC_VECTOR, EXC_WAIT1, EXC_WAIT2, EXC_JUMP,
        DONE
    } ctrlState_t;

    typedef enum logic [4:0] {
        CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT,
        CLS_ADDI, CLS_ADDIU,
        CLS_BEQ, CLS_BNE, CLS_BLE, CLS_BGT,
        CLS_LW, CLS_SW,
        CLS_J, CLS_JAL, CLS_JR,
        CLS_MULT, CLS_DIV,
        CLS_ILLEGAL
    } instrClass_t;

    typedef enum logic [1:0] {
        CAUSE_ILLEGAL,
        CAUSE_OVERFLOW,
        CAUSE_DIVZERO
    } excCause_t;

    localparam aluOp_t ALU_PASS = 3'd0;
    localparam aluOp_t ALU_ADD  = 3'd1;
    localparam aluOp_t ALU_SUB  = 3'd2;
    localparam aluOp_t ALU_AND  = 3'd3;
    localparam aluOp_t ALU_CMP  = 3'd7;

    localparam pcSource_t PC_SRC_MEM    = 3'd0; // Exception vector word
    localparam pcSource_t PC_SRC_ALU    = 3'd1;
    localparam pcSource_t PC_SRC_ALUOUT = 3'd2; // Branch target
    localparam pcSource_t PC_SRC_JUMP   = 3'd3;

    localparam regDst_t DST_RT = 2'd0;
    localparam regDst_t DST_RD = 2'd1;
    localparam regDst_t DST_RA = 2'd2;

    localparam memToReg_t WB_ALUOUT = 3'd0;
    localparam memToReg_t WB_MEM    = 3'd1;
    localparam memToReg_t WB_LESS   = 3'd5;

    localparam aluSrcA_t SRCA_PC   = 2'd0;
    localparam aluSrcA_t SRCA_REGA = 2'd1;

    localparam aluSrcB_t SRCB_REGB  = 2'd0;
    localparam aluSrcB_t SRCB_FOUR  = 2'd1;
    localparam aluSrcB_t SRCB_IMM   = 2'd2;
    localparam aluSrcB_t SRCB_BROFF = 2'd3; // Shifted immediate

    localparam iorD_t ADDR_PC           = 3'd0;
    localparam iorD_t ADDR_ALUOUT       = 3'd1;
    localparam iorD_t ADDR_VEC_ILLEGAL  = 3'd3;
    localparam iorD_t ADDR_VEC_OVERFLOW = 3'd4;
    localparam iorD_t ADDR_VEC_DIVZERO  = 3'd5;

    // Opcode field
    localparam opcode_t OP_RFORMAT = 6'h00;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLE     = 6'h06;
    localparam opcode_t OP_BGT     = 6'h07;
    localparam opcode_t OP_LW      = 6'h0f;
    localparam opcode_t OP_SW      = 6'h2b;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;

    // Funct field, R-format only
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_MULT = 6'h18;
    localparam funct_t FN_DIV  = 6'h1a;

endpackage

//--- rtl/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  ctrlPkg::opcode_t     opcode,
    input  ctrlPkg::funct_t      funct,
    output ctrlPkg::instrClass_t instrClass
);
    import ctrlPkg::*;

    always_comb begin
        instrClass = CLS_ILLEGAL;
        case (opcode)
            OP_RFORMAT: begin
                case (funct)
                    FN_ADD:  instrClass = CLS_ADD;
                    FN_SUB:  instrClass = CLS_SUB;
                    FN_AND:  instrClass = CLS_AND;
                    FN_SLT:  instrClass = CLS_SLT;
                    FN_JR:   instrClass = CLS_JR;
                    FN_MULT: instrClass = CLS_MULT;
                    FN_DIV:  instrClass = CLS_DIV;
                    default: instrClass = CLS_ILLEGAL; // Unknown funct
                endcase
            end
            OP_ADDI:  instrClass = CLS_ADDI;
            OP_ADDIU: instrClass = CLS_ADDIU;
            OP_BEQ:   instrClass = CLS_BEQ;
            OP_BNE:   instrClass = CLS_BNE;
            OP_BLE:   instrClass = CLS_BLE;
            OP_BGT:   instrClass = CLS_BGT;
            OP_LW:    instrClass = CLS_LW;
            OP_SW:    instrClass = CLS_SW;
            OP_J:     instrClass = CLS_J;
            OP_JAL:   instrClass = CLS_JAL;
            default:  instrClass = CLS_ILLEGAL;
        endcase

        // Sequencer and output decode both branch on this
        assert (!$isunknown(instrClass))
            else $error("instrDecoder: instruction class is unknown");
    end

endmodule

//--- rtl/stateSequencer.sv
`timescale 1ns/1ns

module stateSequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlPkg::instrClass_t instrClass,
    input  logic                 overflow,
    input  logic                 multStop,
    input  logic                 divStop,
    input  logic                 divZero,
    output ctrlPkg::ctrlState_t  state,
    output ctrlPkg::excCause_t   cause
);
    import ctrlPkg::*;

    ctrlState_t nextState;
    excCause_t  nextCause;
    logic       loadCause;

    always_comb begin
        nextState = FETCH1;
        nextCause = CAUSE_ILLEGAL;
        loadCause = 1'b0;
        case (state)
            FETCH1:  nextState = FETCH2;
            FETCH2:  nextState = FETCH3;
            FETCH3:  nextState = DECODE1;
            DECODE1: nextState = DECODE2;
            DECODE2: nextState = EXECUTE;
            EXECUTE: begin
                case (instrClass)
                    CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT: nextState = WRITE_RD;
                    CLS_ADDI, CLS_ADDIU:                nextState = IMM_CHECK;
                    CLS_BEQ, CLS_BNE, CLS_BLE, CLS_BGT: nextState = BRANCH;
                    CLS_J, CLS_JAL, CLS_JR:             nextState = JUMP;
                    CLS_LW, CLS_SW:                     nextState = MEM_WAIT1;
                    CLS_MULT, CLS_DIV:                  nextState = MULDIV_WAIT;
                    default: begin
                        nextState = EXC_SAVE;
                        nextCause = CAUSE_ILLEGAL;
                        loadCause = 1'b1;
                    end
                endcase
            end
            IMM_CHECK: begin
                // Only addi traps, addiu ignores the flag
                if (instrClass == CLS_ADDI && overflow) begin
                    nextState = EXC_SAVE;
                    nextCause = CAUSE_OVERFLOW;
                    loadCause = 1'b1;
                end else begin
                    nextState = WRITE_RT;
                end
            end
            MEM_WAIT1:  nextState = MEM_WAIT2;
            MEM_WAIT2:  nextState = MEM_ACCESS;
            MULDIV_WAIT: begin
                nextState = MULDIV_WAIT; // Hold until the unit finishes
                if (instrClass == CLS_DIV) begin
                    if (divZero) begin
                        nextState = EXC_SAVE;
                        nextCause = CAUSE_DIVZERO;
                        loadCause = 1'b1;
                    end else if (divStop) begin
                        nextState = HILO_WB;
                    end
                end else if (multStop) begin
                    nextState = HILO_WB;
                end
            end
            EXC_SAVE:   nextState = EXC_VECTOR;
            EXC_VECTOR: nextState = EXC_WAIT1;
            EXC_WAIT1:  nextState = EXC_WAIT2;
            EXC_WAIT2:  nextState = EXC_JUMP;
            WRITE_RD, WRITE_RT, MEM_ACCESS, BRANCH, JUMP, HILO_WB, EXC_JUMP: begin
                nextState = DONE;
            end
            DONE:    nextState = FETCH1;
            default: nextState = FETCH1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH1;
        end else begin
            state <= nextState;
        end
    end

    // Cause picks the vector address for the rest of the trap
    always_ff @(posedge clk) begin
        if (reset) begin
            cause <= CAUSE_ILLEGAL;
        end else if (loadCause) begin
            cause <= nextCause;
        end
    end

    resetToFetch: assert property (@(posedge clk) $fell(reset) |-> state == FETCH1)
        else $error("stateSequencer: not in FETCH1 after reset");

    doneToFetch: assert property (
        @(posedge clk) disable iff (reset) state == DONE |=> state == FETCH1
    ) else $error("stateSequencer: DONE not followed by FETCH1");

endmodule

//--- rtl/datapathControl.sv
`timescale 1ns/1ns

module datapathControl (
    input  ctrlPkg::ctrlState_t  state,
    input  ctrlPkg::instrClass_t instrClass,
    input  ctrlPkg::excCause_t   cause,
    input  logic                 equal,
    input  logic                 greater,
    input  logic                 less,
    output logic                 memWrite,
    output logic                 pcWrite,
    output logic                 irWrite,
    output logic                 regWrite,
    output logic                 abWrite,
    output logic                 hiloWrite,
    output logic                 aluOutWrite,
    output logic                 epcWrite,
    output logic                 mulStart,
    output logic                 divStart,
    output logic                 hiloSelect,
    output ctrlPkg::aluOp_t      aluOp,
    output ctrlPkg::regDst_t     regDst,
    output ctrlPkg::memToReg_t   memToReg,
    output ctrlPkg::pcSource_t   pcSource,
    output ctrlPkg::aluSrcA_t    aluSrcA,
    output ctrlPkg::aluSrcB_t    aluSrcB,
    output ctrlPkg::iorD_t       iorD
);
    import ctrlPkg::*;

    logic  branchTaken;
    iorD_t vectorAddr;

    always_comb begin
        case (instrClass)
            CLS_BEQ: branchTaken = equal;
            CLS_BNE: branchTaken = !equal;
            CLS_BGT: branchTaken = greater;
            CLS_BLE: branchTaken = !greater;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        case (cause)
            CAUSE_OVERFLOW: vectorAddr = ADDR_VEC_OVERFLOW;
            CAUSE_DIVZERO:  vectorAddr = ADDR_VEC_DIVZERO;
            default:        vectorAddr = ADDR_VEC_ILLEGAL;
        endcase
    end

    always_comb begin
        memWrite    = 1'b0;
        pcWrite     = 1'b0;
        irWrite     = 1'b0;
        regWrite    = 1'b0;
        abWrite     = 1'b0;
        hiloWrite   = 1'b0;
        aluOutWrite = 1'b0;
        epcWrite    = 1'b0;
        mulStart    = 1'b0;
        divStart    = 1'b0;
        hiloSelect  = 1'b0;
        aluOp       = ALU_PASS;
        regDst      = DST_RT;
        memToReg    = WB_ALUOUT;
        pcSource    = PC_SRC_MEM;
        aluSrcA     = SRCA_PC;
        aluSrcB     = SRCB_REGB;
        iorD        = ADDR_PC;

        case (state)
            FETCH1: begin // PC+4 while memory reads the instruction
                aluSrcA = SRCA_PC;
                aluSrcB = SRCB_FOUR;
                aluOp   = ALU_ADD;
                iorD    = ADDR_PC;
            end
            FETCH2: begin
                pcWrite  = 1'b1;
                pcSource = PC_SRC_ALU;
            end
            FETCH3:  irWrite = 1'b1;
            DECODE1: begin // Speculative branch target
                aluOutWrite = 1'b1;
                aluSrcB     = SRCB_BROFF;
                aluOp       = ALU_ADD;
            end
            DECODE2: abWrite = 1'b1;
            EXECUTE: begin
                case (instrClass)
                    CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT, CLS_ADDI, CLS_ADDIU: begin
                        aluOutWrite = 1'b1;
                        aluSrcA     = SRCA_REGA;
                        aluSrcB     = (instrClass == CLS_ADDI || instrClass == CLS_ADDIU)
                                      ? SRCB_IMM : SRCB_REGB;
                        case (instrClass)
                            CLS_SUB: aluOp = ALU_SUB;
                            CLS_AND: aluOp = ALU_AND;
                            CLS_SLT: aluOp = ALU_CMP;
                            default: aluOp = ALU_ADD;
                        endcase
                    end
                    CLS_BEQ, CLS_BNE, CLS_BLE, CLS_BGT: begin
                        aluSrcA = SRCA_REGA; // rs against rt
                        aluOp   = ALU_CMP;
                    end
                    CLS_LW, CLS_SW: begin // Effective address
                        aluOutWrite = 1'b1;
                        aluSrcA     = SRCA_REGA;
                        aluSrcB     = SRCB_IMM;
                        aluOp       = ALU_ADD;
                    end
                    CLS_JAL:  aluOutWrite = 1'b1; // Return address
                    CLS_MULT: mulStart = 1'b1;
                    CLS_DIV:  divStart = 1'b1;
                    default: ;
                endcase
            end
            WRITE_RD: begin
                regWrite = 1'b1;
                regDst   = DST_RD;
                memToReg = (instrClass == CLS_SLT) ? WB_LESS : WB_ALUOUT;
            end
            WRITE_RT: begin
                regWrite = 1'b1;
                regDst   = DST_RT;
                memToReg = WB_ALUOUT;
            end
            MEM_WAIT1, MEM_WAIT2: iorD = ADDR_ALUOUT;
            MEM_ACCESS: begin
                iorD = ADDR_ALUOUT;
                if (instrClass == CLS_SW) begin
                    memWrite = 1'b1;
                end else begin
                    regWrite = 1'b1;
                    regDst   = DST_RT;
                    memToReg = WB_MEM;
                end
            end
            BRANCH: begin
                pcWrite  = branchTaken;
                pcSource = PC_SRC_ALUOUT;
            end
            JUMP: begin
                pcWrite = 1'b1;
                if (instrClass == CLS_JR) begin
                    pcSource = PC_SRC_ALU;
                    aluSrcA  = SRCA_REGA;
                    aluOp    = ALU_PASS;
                end else begin
                    pcSource = PC_SRC_JUMP;
                end
                if (instrClass == CLS_JAL) begin
                    regWrite = 1'b1;
                    regDst   = DST_RA;
                    memToReg = WB_ALUOUT;
                end
            end
            HILO_WB: begin
                hiloWrite  = 1'b1;
                hiloSelect = (instrClass == CLS_DIV);
            end
            EXC_SAVE: begin // EPC gets the faulting PC
                epcWrite = 1'b1;
                aluSrcA  = SRCA_PC;
                aluSrcB  = SRCB_FOUR;
                aluOp    = ALU_SUB;
            end
            EXC_VECTOR, EXC_WAIT1, EXC_WAIT2: iorD = vectorAddr;
            EXC_JUMP: begin
                pcWrite  = 1'b1;
                pcSource = PC_SRC_MEM;
            end
            default: ;
        endcase

        assert (!(memWrite && regWrite))
            else $error("datapathControl: memWrite and regWrite both high");
        // The ALU flags come from one compare
        if (state == BRANCH) begin
            assert ($onehot0({equal, greater, less}))
                else $error("datapathControl: compare flags not exclusive");
        end
    end

endmodule

//--- rtl/ctrlUnit.sv
`timescale 1ns/1ns

module ctrlUnit (
    input  logic               clk,
    input  logic               reset,
    input  ctrlPkg::opcode_t   opcode,
    input  ctrlPkg::funct_t    funct,
    input  logic               overflow,
    input  logic               equal,
    input  logic               greater,
    input  logic               less,
    input  logic               multStop,
    input  logic               divStop,
    input  logic               divZero,
    output logic               memWrite,
    output logic               pcWrite,
    output logic               irWrite,
    output logic               regWrite,
    output logic               abWrite,
    output logic               hiloWrite,
    output logic               aluOutWrite,
    output logic               epcWrite,
    output logic               mulStart,
    output logic               divStart,
    output logic               hiloSelect,
    output ctrlPkg::aluOp_t    aluOp,
    output ctrlPkg::regDst_t   regDst,
    output ctrlPkg::memToReg_t memToReg,
    output ctrlPkg::pcSource_t pcSource,
    output ctrlPkg::aluSrcA_t  aluSrcA,
    output ctrlPkg::aluSrcB_t  aluSrcB,
    output ctrlPkg::iorD_t     iorD
);
    import ctrlPkg::*;

    instrClass_t instrClass;
    ctrlState_t  state;
    excCause_t   cause;

    instrDecoder instrDecoder_inst (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    stateSequencer stateSequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .overflow   (overflow),
        .multStop   (multStop),
        .divStop    (divStop),
        .divZero    (divZero),
        .state      (state),
        .cause      (cause)
    );

    datapathControl datapathControl_inst (
        .state       (state),
        .instrClass  (instrClass),
        .cause       (cause),
        .equal       (equal),
        .greater     (greater),
        .less        (less),
        .memWrite    (memWrite),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .abWrite     (abWrite),
        .hiloWrite   (hiloWrite),
        .aluOutWrite (aluOutWrite),
        .epcWrite    (epcWrite),
        .mulStart    (mulStart),
        .divStart    (divStart),
        .hiloSelect  (hiloSelect),
        .aluOp       (aluOp),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .pcSource    (pcSource),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .iorD        (iorD)
    );

endmodule

//--- verif/ctrlUnitTb.sv
`timescale 1ns/1ns

module ctrlUnitTb;
    import ctrlPkg::*;

    typedef struct packed {
        opcode_t op;
        funct_t  fn;
        logic    ovf;
        logic    eq;
        logic    gt;
        logic    lt;
        logic    dz;
        int      waitCount;
        int      cycles;    // irWrite to irWrite
        int      nReg;
        int      dst;
        int      wb;
        int      nMem;
        int      nPc;       // Not counting the fetch pcWrite
        int      pcSrc;
        int      nEpc;
        int      vec;
        int      nHilo;
        int      hiSel;
    } testVec_t;

    logic       clk;
    logic       reset;
    opcode_t    opcode;
    funct_t     funct;
    logic       overflow, equal, greater, less;
    logic       multStop, divStop, divZero;
    logic       memWrite, pcWrite, irWrite, regWrite, abWrite;
    logic       hiloWrite, aluOutWrite, epcWrite, mulStart, divStart, hiloSelect;
    aluOp_t     aluOp;
    regDst_t    regDst;
    memToReg_t  memToReg;
    pcSource_t  pcSource;
    aluSrcA_t   aluSrcA;
    aluSrcB_t   aluSrcB;
    iorD_t      iorD;

    testVec_t   tests[64];
    string      names[64];
    int         numTests;
    bit         testsLoaded;

    ctrlUnit ctrlUnit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [9:0] enableBits();
        return {memWrite, pcWrite, irWrite, regWrite, abWrite,
                hiloWrite, aluOutWrite, epcWrite, mulStart, divStart};
    endfunction

    task automatic checkValue(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s: expected %0d, actual %0d", what, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic loadTests();
        int    fd;
        int    count;
        int    split;
        int    col[19];
        string line;
        string rest;
        fd = $fopen("verif/ctrlInput.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/ctrlInput.txt");
            $display("Test failed");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            split = 0;
            while (split < line.len() && line.getc(split) != " ") split++;
            rest = line.substr(split, line.len() - 1);
            count = $sscanf(rest, "%h %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
                col[17], col[18]);
            if (count != 19 || numTests == 64) begin
                $display("Stimulus line could not be read: %s", line);
                $display("Test failed");
                $fatal(1);
            end
            names[numTests]           = line.substr(0, split - 1);
            tests[numTests].op        = col[0][5:0];
            tests[numTests].fn        = col[1][5:0];
            tests[numTests].ovf       = col[2][0];
            tests[numTests].eq        = col[3][0];
            tests[numTests].gt        = col[4][0];
            tests[numTests].lt        = col[5][0];
            tests[numTests].dz        = col[6][0];
            tests[numTests].waitCount = col[7];
            tests[numTests].cycles    = col[8];
            tests[numTests].nReg      = col[9];
            tests[numTests].dst       = col[10];
            tests[numTests].wb        = col[11];
            tests[numTests].nMem      = col[12];
            tests[numTests].nPc       = col[13];
            tests[numTests].pcSrc     = col[14];
            tests[numTests].nEpc      = col[15];
            tests[numTests].vec       = col[16];
            tests[numTests].nHilo     = col[17];
            tests[numTests].hiSel     = col[18];
            numTests++;
        end
        $fclose(fd);
    endtask

    // FETCH1 idle, FETCH2 pcWrite only, FETCH3 irWrite only
    task automatic checkFirstFetch();
        int cyc;
        int expected;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc == 3) expected = int'(10'b00_1000_0000);
            else if (cyc == 2) expected = int'(10'b01_0000_0000);
            else expected = 0;
            checkValue($sformatf("first fetch enables, cycle %0d", cyc), expected,
                int'(enableBits()));
            if (cyc == 1) begin // PC+4 on the ALU
                checkValue("first fetch aluSrcA", int'(SRCA_PC), int'(aluSrcA));
                checkValue("first fetch aluSrcB", int'(SRCB_FOUR), int'(aluSrcB));
                checkValue("first fetch aluOp", int'(ALU_ADD), int'(aluOp));
                checkValue("first fetch iorD", int'(ADDR_PC), int'(iorD));
            end
            if (pcWrite) checkValue("first fetch pcSource", int'(PC_SRC_ALU), int'(pcSource));
        end while (!irWrite);
        checkValue("first fetch cycles", 3, cyc);
    endtask

    task automatic runInstruction(input int t);
        testVec_t  tv;
        string     name;
        int        cyc;
        int        nReg, nMem, nPc, nEpc, nHilo;
        int        waitLeft;
        logic      stopIsDiv;
        logic      pendingPc;
        pcSource_t pendingSrc;
        logic      vectorNext;
        tv = tests[t];
        name = names[t];
        cyc = 0;
        nReg = 0;
        nMem = 0;
        nPc = 0;
        nEpc = 0;
        nHilo = 0;
        waitLeft = 0;
        stopIsDiv = 1'b0;
        pendingPc = 1'b0;
        pendingSrc = PC_SRC_MEM;
        vectorNext = 1'b0;

        // IR was loaded on the last edge, so the next instruction goes on now
        @(posedge clk);
        #1;
        opcode   = tv.op;
        funct    = tv.fn;
        overflow = tv.ovf;
        equal    = tv.eq;
        greater  = tv.gt;
        less     = tv.lt;
        divZero  = tv.dz;
        multStop = 1'b0;
        divStop  = 1'b0;
        do begin
            if (cyc > 0) begin
                @(posedge clk);
                #1;
                if (waitLeft > 0) begin
                    waitLeft--;
                    if (waitLeft == 0) begin
                        if (stopIsDiv) divStop = 1'b1;
                        else multStop = 1'b1;
                    end
                end
            end
            @(negedge clk);
            cyc++;
            if (vectorNext) begin // EXC_VECTOR follows EXC_SAVE
                checkValue({name, " vector"}, tv.vec, int'(iorD));
                vectorNext = 1'b0;
            end
            if (pendingPc) begin
                if (irWrite) begin
                    checkValue({name, " fetch pcSource"}, int'(PC_SRC_ALU), int'(pendingSrc));
                end else begin
                    nPc++;
                    checkValue({name, " pcSource"}, tv.pcSrc, int'(pendingSrc));
                end
            end
            pendingPc = pcWrite;
            pendingSrc = pcSource;
            if (regWrite) begin
                nReg++;
                checkValue({name, " regDst"}, tv.dst, int'(regDst));
                checkValue({name, " memToReg"}, tv.wb, int'(memToReg));
            end
            if (memWrite) nMem++;
            if (epcWrite) begin // EPC takes PC-4
                nEpc++;
                vectorNext = 1'b1;
                checkValue({name, " EPC aluSrcA"}, int'(SRCA_PC), int'(aluSrcA));
                checkValue({name, " EPC aluSrcB"}, int'(SRCB_FOUR), int'(aluSrcB));
                checkValue({name, " EPC aluOp"}, int'(ALU_SUB), int'(aluOp));
            end
            if (hiloWrite) begin
                nHilo++;
                checkValue({name, " hiloSelect"}, tv.hiSel, int'(hiloSelect));
            end
            if (mulStart || divStart) begin
                waitLeft = tv.waitCount;
                stopIsDiv = divStart;
            end
        end while (!irWrite);

        checkValue({name, " cycles"}, tv.cycles, cyc);
        checkValue({name, " regWrite count"}, tv.nReg, nReg);
        checkValue({name, " memWrite count"}, tv.nMem, nMem);
        checkValue({name, " pcWrite count"}, tv.nPc, nPc);
        checkValue({name, " epcWrite count"}, tv.nEpc, nEpc);
        checkValue({name, " hiloWrite count"}, tv.nHilo, nHilo);
    endtask

    initial begin
        int t;
        reset    = 1'b1;
        opcode   = OP_RFORMAT;
        funct    = FN_ADD;
        overflow = 1'b0;
        equal    = 1'b0;
        greater  = 1'b0;
        less     = 1'b0;
        multStop = 1'b0;
        divStop  = 1'b0;
        divZero  = 1'b0;
        loadTests();
        if (numTests == 0) begin
            $display("The stimulus file holds no test lines");
            $display("Test failed");
            $fatal(1);
        end
        testsLoaded = 1'b1;

        repeat (9) begin
            @(negedge clk);
            checkValue("enables during reset", 0, int'(enableBits()));
        end
        @(posedge clk);
        #1;
        reset = 1'b0;

        checkFirstFetch();
        for (t = 0; t < numTests; t++) begin
            runInstruction(t);
        end
        $display("Test passed");
        $finish;
    end

    // Longest instruction is well under 20 cycles
    initial begin
        wait (testsLoaded);
        repeat (numTests * 20 + 50) @(posedge clk);
        $display("Watchdog: the run timed out after %0d cycles", numTests * 20 + 50);
        $display("Test failed");
        $fatal(1);
    end

endmodule

//--- src.f
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/stateSequencer.sv
rtl/datapathControl.sv
rtl/ctrlUnit.sv
verif/ctrlUnitTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ctrlUnitTb -f src.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "Test passed" \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not succeed"; exit 1; }

//--- verif/ctrlInput.txt
# name op fn | ovf eq gt lt divZero | waitCycles irWriteGap | regWrites regDst memToReg
#   memWrites pcWrites pcSource | epcWrites vector | hiloWrites hiloSelect
add       00 20  0 0 0 0 0  0  8  1 1 0  0  0 0  0 0  0 0
sub       00 22  0 0 0 0 0  0  8  1 1 0  0  0 0  0 0  0 0
and       00 24  0 0 0 0 0  0  8  1 1 0  0  0 0  0 0  0 0
slt       00 2a  0 0 0 1 0  0  8  1 1 5  0  0 0  0 0  0 0
addi      08 00  0 0 0 0 0  0  9  1 0 0  0  0 0  0 0  0 0
addiu     09 00  0 0 0 0 0  0  9  1 0 0  0  0 0  0 0  0 0
addiOvf   08 00  1 0 0 0 0  0 13  0 0 0  0  1 0  1 4  0 0
addiuOvf  09 00  1 0 0 0 0  0  9  1 0 0  0  0 0  0 0  0 0
beqTaken  04 00  0 1 0 0 0  0  8  0 0 0  0  1 2  0 0  0 0
beqNot    04 00  0 0 1 0 0  0  8  0 0 0  0  0 0  0 0  0 0
bneTaken  05 00  0 0 0 1 0  0  8  0 0 0  0  1 2  0 0  0 0
bneNot    05 00  0 1 0 0 0  0  8  0 0 0  0  0 0  0 0  0 0
bleTaken  06 00  0 0 0 1 0  0  8  0 0 0  0  1 2  0 0  0 0
bleEqual  06 00  0 1 0 0 0  0  8  0 0 0  0  1 2  0 0  0 0
bleNot    06 00  0 0 1 0 0  0  8  0 0 0  0  0 0  0 0  0 0
bgtTaken  07 00  0 0 1 0 0  0  8  0 0 0  0  1 2  0 0  0 0
bgtNot    07 00  0 1 0 0 0  0  8  0 0 0  0  0 0  0 0  0 0
j         02 00  0 0 0 0 0  0  8  0 0 0  0  1 3  0 0  0 0
jal       03 00  0 0 0 0 0  0  8  1 2 0  0  1 3  0 0  0 0
jr        00 08  0 0 0 0 0  0  8  0 0 0  0  1 1  0 0  0 0
lw        0f 00  0 0 0 0 0  0 10  1 0 1  0  0 0  0 0  0 0
sw        2b 00  0 0 0 0 0  0 10  0 0 0  1  0 0  0 0  0 0
mult      00 18  0 0 0 0 0  1  9  0 0 0  0  0 0  0 0  1 0
multSlow  00 18  0 0 0 0 0  4 12  0 0 0  0  0 0  0 0  1 0
div       00 1a  0 0 0 0 0  3 11  0 0 0  0  0 0  0 0  1 1
divZero   00 1a  0 0 0 0 1  2 13  0 0 0  0  1 0  1 5  0 0
badOpcode 3f 00  0 0 0 0 0  0 12  0 0 0  0  1 0  1 3  0 0
badFunct  00 3f  0 0 0 0 0  0 12  0 0 0  0  1 0  1 3  0 0
